// File: common/scene_settings.svh
/* Scene settings for the 1080p snow overlay
   Screen size, sprite geometry, pellet grid and colours */

`ifndef SCENE_SETTINGS_SVH
`define SCENE_SETTINGS_SVH

// Active raster size
`define SCREEN_W        1920
`define SCREEN_H        1080

// Snowflakes
`define FLAKE_COUNT     12
`define FLAKE_HALF      8        // Half size of the flake box
`define FLAKE_X_STEP    137      // Sideways jump on wrap

// Pac-Man centre and shape
`define PAC_X           960
`define PAC_Y           250
`define PAC_R_SQ        900      // Radius 30 squared
`define PAC_MOUTH       45       // Mouth slope in 64ths

// Pellet field
`define DOT_MIN_X       80
`define DOT_MAX_X       1840
`define DOT_MIN_Y       80
`define DOT_MAX_Y       1000
`define DOT_PITCH       50
`define DOT_LO          22       // Pellet starts here within a cell
`define DOT_HI          28       // First position past the pellet

// Layer colours, {R, G, B}
`define COLOR_FLAKE     24'hFF_FF_FF
`define COLOR_DOT       24'hFF_FF_FF
`define COLOR_PACMAN    24'hFF_FF_00

`endif

// File: common/scene_pkg.sv
/* Shared types for the snow scene overlay
   Pixel colour, raster position, sync and blanking bundles */

`default_nettype none

package scene_pkg;

    // Pixel colour, red in the top byte
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Position inside the active raster
    typedef struct packed {
        logic [11:0] x;    // Pixel within the line
        logic [10:0] y;    // Line within the frame
    } raster_pos_t;

    // Video sync bits
    typedef struct packed {
        logic d;    // Data enable style sync
        logic v;
        logic h;
    } sync_t;

    // Blanking bits
    typedef struct packed {
        logic v;
        logic h;
    } blank_t;

endpackage

`default_nettype wire

// File: rtl/raster_tracker.sv
/* Raster tracker
   Rebuilds x and y from blanking edges and flags each new frame */

`timescale 1ns/1ps
`default_nettype none

`include "scene_settings.svh"

module raster_tracker
    import scene_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire logic        cen_i,        // Pixel clock enable
    input  wire blank_t      blank_i,
    output raster_pos_t      pos_o,
    output logic             frame_tick_o  // One enabled cycle per frame
);

    blank_t      blank_q;    // Blank bits from the last enabled cycle
    raster_pos_t pos_q;

    logic h_fall;
    logic h_rise;
    logic v_fall;

    // Edges against the stored blank bits
    assign h_fall = blank_q.h & ~blank_i.h;    // Line starts
    assign h_rise = ~blank_q.h & blank_i.h;    // Line ends
    assign v_fall = blank_q.v & ~blank_i.v;    // Frame starts

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            blank_q <= '0;
            pos_q   <= '0;
        end else if (cen_i) begin
            blank_q <= blank_i;

            // Pixel counter
            if (h_fall) begin
                pos_q.x <= '0;
            end else if (!blank_i.h) begin
                pos_q.x <= pos_q.x + 12'd1;
            end

            // Line counter, frame start wins over line end
            if (v_fall) begin
                pos_q.y <= '0;
            end else if (h_rise) begin
                pos_q.y <= pos_q.y + 11'd1;
            end
        end
    end

    assign pos_o = pos_q;

    // Tick lands on the same edge that clears y
    assign frame_tick_o = cen_i & v_fall;

    // Pixel counter stays inside the active line
    a_x_range: assert property (
        @(posedge clk_i) disable iff (rst_i)
        pos_o.x < 12'(`SCREEN_W)
    );

endmodule

`default_nettype wire

// File: snowflake/snowflake_unit.sv
/* Snowflake unit
   One falling flake with wrap and sideways reshuffle, plus its shape test */

`timescale 1ns/1ps
`default_nettype none

`include "scene_settings.svh"

module snowflake_unit
    import scene_pkg::*;
#(
    parameter int unsigned FLAKE_INDEX = 0
) (
    input  wire logic        clk_i,
    input  wire logic        rst_i,
    input  wire logic        cen_i,
    input  wire logic        frame_tick_i,   // Move once per frame
    input  wire raster_pos_t pos_i,
    output logic             hit_o
);

    // Start spread across the screen, speed 1 to 8
    localparam int unsigned INIT_X = (160 * FLAKE_INDEX) % `SCREEN_W;
    localparam int unsigned INIT_Y = (90 * FLAKE_INDEX) % `SCREEN_H;
    localparam logic [3:0]  FLAKE_SPEED = 4'((FLAKE_INDEX % 8) + 1);
    localparam int unsigned ARM_W = 2;     // Arm thickness

    logic [11:0] flake_x_q;
    logic [10:0] flake_y_q;

    logic [11:0] y_sum;        // Next y before wrap
    logic [11:0] x_shift;      // Reshuffled x before modulo
    logic [11:0] x_wrapped;

    logic [11:0] dx;
    logic [10:0] dy;
    logic [12:0] d_sum;
    logic        in_box;
    logic        in_shape;

    // Motion
    assign y_sum     = {1'b0, flake_y_q} + {8'd0, FLAKE_SPEED};
    assign x_shift   = flake_x_q + 12'(`FLAKE_X_STEP);
    assign x_wrapped = (x_shift >= 12'(`SCREEN_W)) ? x_shift - 12'(`SCREEN_W) : x_shift;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            flake_x_q <= 12'(INIT_X);
            flake_y_q <= 11'(INIT_Y);
        end else if (cen_i && frame_tick_i) begin
            if (y_sum >= 12'(`SCREEN_H)) begin
                flake_y_q <= '0;            // Back to the top
                flake_x_q <= x_wrapped;     // New column
            end else begin
                flake_y_q <= y_sum[10:0];
            end
        end
    end

    // Absolute distances from the flake centre
    assign dx = (pos_i.x >= flake_x_q) ? pos_i.x - flake_x_q : flake_x_q - pos_i.x;
    assign dy = (pos_i.y >= flake_y_q) ? pos_i.y - flake_y_q : flake_y_q - pos_i.y;
    assign d_sum = {1'b0, dx} + {2'b00, dy};

    assign in_box = (dx <= 12'(`FLAKE_HALF)) && (dy <= 11'(`FLAKE_HALF));

    always_comb begin
        in_shape = 1'b0;
        if (dx < 12'(ARM_W) && dy < 11'(ARM_W)) begin
            in_shape = 1'b1;                            // Centre dot
        end else if (dy < 11'(ARM_W) && dx < 12'(`FLAKE_HALF)) begin
            in_shape = 1'b1;                            // Horizontal arm
        end else if (dx < 12'(ARM_W) && dy < 11'(`FLAKE_HALF)) begin
            in_shape = 1'b1;                            // Vertical arm
        end else if (dx == {1'b0, dy} && dx < 12'(`FLAKE_HALF)) begin
            in_shape = 1'b1;                            // Diagonals
        end else if (d_sum < 13'd3 && (dx > 12'd1 || dy > 11'd1)) begin
            in_shape = 1'b1;                            // Small ring near the centre
        end
    end

    assign hit_o = in_box & in_shape;

    // Position never leaves the raster
    a_y_inside: assert property (
        @(posedge clk_i) disable iff (rst_i)
        flake_y_q < 11'(`SCREEN_H)
    );

    a_x_inside: assert property (
        @(posedge clk_i) disable iff (rst_i)
        flake_x_q < 12'(`SCREEN_W)
    );

endmodule

`default_nettype wire

// File: rtl/pacman_sprite.sv
/* Pac-Man sprite
   Filled circle with a wedge mouth opening to the right */

`timescale 1ns/1ps
`default_nettype none

`include "scene_settings.svh"

module pacman_sprite
    import scene_pkg::*;
(
    input  wire raster_pos_t pos_i,
    output logic             hit_o
);

    logic signed [31:0] rel_x;     // Offset from the centre
    logic signed [31:0] rel_y;
    logic signed [31:0] abs_y;
    logic signed [31:0] dist_sq;
    logic               in_circle;
    logic               in_mouth;

    // Signed offsets, 32 bits so the squares cannot overflow
    assign rel_x = $signed({20'd0, pos_i.x}) - 32'sd`PAC_X;
    assign rel_y = $signed({21'd0, pos_i.y}) - 32'sd`PAC_Y;
    assign abs_y = (rel_y < 0) ? -rel_y : rel_y;

    assign dist_sq   = rel_x * rel_x + rel_y * rel_y;
    assign in_circle = dist_sq < 32'sd`PAC_R_SQ;

    // Mouth wedge, 64*|dy| < slope*dx on the right half
    assign in_mouth = (rel_x > 0) && ((abs_y <<< 6) < rel_x * 32'sd`PAC_MOUTH);

    assign hit_o = in_circle & ~in_mouth;

endmodule

`default_nettype wire

// File: rtl/scene_compositor.sv
/* Scene compositor
   Pellet grid, layer priority and the registered pixel and sync outputs */

`timescale 1ns/1ps
`default_nettype none

`include "scene_settings.svh"

module scene_compositor
    import scene_pkg::*;
(
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,
    input  wire logic                    cen_i,
    input  wire raster_pos_t             pos_i,
    input  wire logic [`FLAKE_COUNT-1:0] flake_hit_i,   // One bit per flake
    input  wire logic                    pac_hit_i,
    input  wire sync_t                   sync_i,
    output rgb_t                         rgb_o,
    output sync_t                        sync_o
);

    logic [11:0] cell_x;       // Position within a pellet cell
    logic [10:0] cell_y;
    logic        in_field;
    logic        dot_hit;

    rgb_t  pix;
    rgb_t  rgb_q;
    sync_t sync_q;

    // Pellet grid
    assign cell_x = pos_i.x % 12'(`DOT_PITCH);
    assign cell_y = pos_i.y % 11'(`DOT_PITCH);

    assign in_field = (pos_i.x >= 12'(`DOT_MIN_X)) && (pos_i.x < 12'(`DOT_MAX_X)) &&
                      (pos_i.y >= 11'(`DOT_MIN_Y)) && (pos_i.y < 11'(`DOT_MAX_Y));

    assign dot_hit = in_field &&
                     (cell_x >= 12'(`DOT_LO)) && (cell_x < 12'(`DOT_HI)) &&
                     (cell_y >= 11'(`DOT_LO)) && (cell_y < 11'(`DOT_HI));

    // Later layers overwrite earlier ones
    always_comb begin
        pix = '0;                                   // Black background
        if (dot_hit) begin
            pix = rgb_t'(`COLOR_DOT);
        end
        if (pac_hit_i) begin
            pix = rgb_t'(`COLOR_PACMAN);
        end
        for (int i = 0; i < `FLAKE_COUNT; i++) begin
            if (flake_hit_i[i]) begin
                pix = rgb_t'(`COLOR_FLAKE);         // Higher index on top
            end
        end
    end

    // Output stage, sync delayed to line up with the pixel
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rgb_q  <= '0;
            sync_q <= '0;
        end else if (cen_i) begin
            rgb_q  <= pix;
            sync_q <= sync_i;
        end
    end

    assign rgb_o  = rgb_q;
    assign sync_o = sync_q;

    // Held enable freezes the whole output word
    a_hold: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !cen_i |=> $stable({rgb_o, sync_o})
    );

endmodule

`default_nettype wire

// File: rtl/snow_scene_top.sv
/* Snow scene overlay top level
   Raster tracker, snowflake array, Pac-Man sprite and compositor */

`timescale 1ns/1ps
`default_nettype none

`include "scene_settings.svh"

module snow_scene_top
    import scene_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    input  wire logic  cen_i,       // Pixel clock enable
    input  wire rgb_t  vid_rgb_i,   // Incoming video, replaced by the scene
    input  wire blank_t blank_i,
    input  wire sync_t sync_i,
    output sync_t      sync_o,      // Delayed by one enabled cycle
    output rgb_t       rgb_o
);

    raster_pos_t             pos;
    logic                    frame_tick;
    logic [`FLAKE_COUNT-1:0] flake_hit;
    logic                    pac_hit;

    raster_tracker u_raster_tracker (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cen_i        (cen_i),
        .blank_i      (blank_i),
        .pos_o        (pos),
        .frame_tick_o (frame_tick)
    );

    // One unit per flake, index sets start point and speed
    for (genvar i = 0; i < `FLAKE_COUNT; i++) begin : gen_flakes
        snowflake_unit #(
            .FLAKE_INDEX (i)
        ) u_flake (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .cen_i        (cen_i),
            .frame_tick_i (frame_tick),
            .pos_i        (pos),
            .hit_o        (flake_hit[i])
        );
    end

    pacman_sprite u_pacman (
        .pos_i (pos),
        .hit_o (pac_hit)
    );

    scene_compositor u_compositor (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cen_i       (cen_i),
        .pos_i       (pos),
        .flake_hit_i (flake_hit),
        .pac_hit_i   (pac_hit),
        .sync_i      (sync_i),
        .rgb_o       (rgb_o),
        .sync_o      (sync_o)
    );

endmodule

`default_nettype wire

// File: tb/scene_model.svh
/* Reference model for the snow scene testbench
   Raster counters, flake motion and the expected pixel colour */

`ifndef SCENE_MODEL_SVH
`define SCENE_MODEL_SVH

`include "scene_settings.svh"

int   m_x;                    // Model raster position
int   m_y;
logic m_hb_q;                 // Blank bits of the last enabled cycle
logic m_vb_q;
int   m_fx [`FLAKE_COUNT];    // Flake centres
int   m_fy [`FLAKE_COUNT];

function automatic void model_reset();
    m_x    = 0;
    m_y    = 0;
    m_hb_q = 1'b0;
    m_vb_q = 1'b0;
    for (int j = 0; j < `FLAKE_COUNT; j++) begin
        m_fx[j] = (160 * j) % `SCREEN_W;
        m_fy[j] = 90 * j;
    end
endfunction

// One frame of fall, wrap sends the flake to the top of a new column
function automatic void move_flakes();
    int speed;
    for (int j = 0; j < `FLAKE_COUNT; j++) begin
        speed = (j % 8) + 1;
        if (m_fy[j] + speed >= `SCREEN_H) begin
            m_fy[j] = 0;
            m_fx[j] = (m_fx[j] + `FLAKE_X_STEP) % `SCREEN_W;
        end else begin
            m_fy[j] = m_fy[j] + speed;
        end
    end
endfunction

// Counters after one enabled cycle
function automatic void model_step(input blank_t blk);
    logic h_fall;
    logic h_rise;
    logic v_fall;
    h_fall = m_hb_q && !blk.h;
    h_rise = !m_hb_q && blk.h;
    v_fall = m_vb_q && !blk.v;
    if (v_fall) begin
        move_flakes();                 // Frame tick
    end
    if (h_fall) begin
        m_x = 0;
    end else if (!blk.h) begin
        m_x = m_x + 1;
    end
    if (v_fall) begin
        m_y = 0;
    end else if (h_rise) begin
        m_y = m_y + 1;
    end
    m_hb_q = blk.h;
    m_vb_q = blk.v;
endfunction

function automatic bit flake_at(input int j, input int x, input int y);
    int dx;
    int dy;
    dx = (x >= m_fx[j]) ? x - m_fx[j] : m_fx[j] - x;
    dy = (y >= m_fy[j]) ? y - m_fy[j] : m_fy[j] - y;
    if (dx > `FLAKE_HALF || dy > `FLAKE_HALF) begin
        return 1'b0;
    end
    return (dx < 2 && dy < 2) || (dy < 2 && dx < `FLAKE_HALF) ||
           (dx < 2 && dy < `FLAKE_HALF) || (dx == dy && dx < `FLAKE_HALF) ||
           (dx + dy < 3 && (dx > 1 || dy > 1));
endfunction

// Circle minus the mouth wedge on the right
function automatic bit pacman_at(input int x, input int y);
    int rx;
    int ry;
    rx = x - `PAC_X;
    ry = y - `PAC_Y;
    if (rx * rx + ry * ry >= `PAC_R_SQ) begin
        return 1'b0;
    end
    return !(rx > 0 && 64 * (ry < 0 ? -ry : ry) < `PAC_MOUTH * rx);
endfunction

function automatic bit dot_at(input int x, input int y);
    return x >= `DOT_MIN_X && x < `DOT_MAX_X && y >= `DOT_MIN_Y && y < `DOT_MAX_Y &&
           x % `DOT_PITCH >= `DOT_LO && x % `DOT_PITCH < `DOT_HI &&
           y % `DOT_PITCH >= `DOT_LO && y % `DOT_PITCH < `DOT_HI;
endfunction

// Bottom layer first, later hits paint over
function automatic logic [23:0] expected_pixel();
    logic [23:0] c;
    c = 24'h0;
    if (dot_at(m_x, m_y)) begin
        c = `COLOR_DOT;
    end
    if (pacman_at(m_x, m_y)) begin
        c = `COLOR_PACMAN;
    end
    for (int j = 0; j < `FLAKE_COUNT; j++) begin
        if (flake_at(j, m_x, m_y)) begin
            c = `COLOR_FLAKE;
        end
    end
    return c;
endfunction

`endif

// File: tb/snow_scene_tb.sv
/* Snow scene testbench
   Drives blanked raster frames with random enable gaps and checks every output pixel */

`timescale 1ns/1ps
`default_nettype none

module snow_scene_tb
    import scene_pkg::*;
();

    logic   clk_i;
    logic   rst_i;
    logic   cen_i;
    rgb_t   vid_rgb_i;
    blank_t blank_i;
    sync_t  sync_i;
    sync_t  sync_o;
    rgb_t   rgb_o;

    rgb_t        exp_rgb;     // Output register as the model sees it
    sync_t       exp_sync;
    string       test_name;
    logic [15:0] lfsr_q;

    `include "scene_model.svh"

    localparam int CLK_HALF_NS = 10;
    localparam int HBLANK      = 8;
    localparam int VBLANK      = 4;
    localparam int TINY_FRAMES = 1082;    // Flake 0 wraps on tick 1080
    // Enabled cycles of all frames, the gapped frame counted five times over
    localparam longint PLAN_CYCLES = 280 * (1000 + HBLANK) + VBLANK +
        TINY_FRAMES * (2 * (64 + HBLANK) + VBLANK) + 16 * (160 + HBLANK) + VBLANK +
        5 * (40 * (200 + HBLANK) + VBLANK) + 100;

    snow_scene_top dut0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .cen_i     (cen_i),
        .vid_rgb_i (vid_rgb_i),
        .blank_i   (blank_i),
        .sync_i    (sync_i),
        .sync_o    (sync_o),
        .rgb_o     (rgb_o)
    );

    always #(CLK_HALF_NS) clk_i = ~clk_i;

    // Galois LFSR, one step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[6:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 16'hB400 : lfsr_q >> 1;
        end
        return v;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    // One clock, inputs change on the falling edge
    task automatic drive_cycle(input logic cen, input blank_t blk);
        sync_t syn;
        @(negedge clk_i);
        syn     = sync_t'(rand_bits(3));
        cen_i   = cen;
        blank_i = blk;
        sync_i  = syn;
        if (cen) begin
            exp_rgb  = rgb_t'(expected_pixel());    // Pixel at the current position
            exp_sync = syn;
            model_step(blk);
        end
    endtask

    // Enabled cycle, optionally behind a short run of held cycles
    task automatic pixel_cycle(input blank_t blk, input bit gaps);
        int n;
        if (gaps && rand_bits(2) == 8'd3) begin
            n = rand_bits(2) + 1;
            repeat (n) drive_cycle(1'b0, blank_t'(rand_bits(2)));    // Junk blank while held
        end
        drive_cycle(1'b1, blk);
    endtask

    task automatic run_frame(input int lines, input int pixels, input bit gaps);
        repeat (VBLANK) pixel_cycle(blank_t'(2'b11), gaps);
        for (int l = 0; l < lines; l++) begin
            repeat (pixels) pixel_cycle(blank_t'(2'b00), gaps);    // Active line
            repeat (HBLANK) pixel_cycle(blank_t'(2'b01), gaps);
        end
    endtask

    // Compare in the middle of the high phase, far from both edges
    always @(posedge clk_i) begin
        #(CLK_HALF_NS / 2);
        assert (rgb_o == exp_rgb && sync_o == exp_sync) else
            fail_run($sformatf("ERROR %s expected rgb %h sync %b actual rgb %h sync %b",
                               test_name, exp_rgb, exp_sync, rgb_o, sync_o));
    end

    initial begin
        #(PLAN_CYCLES * 4 * CLK_HALF_NS);
        fail_run("Timeout: the test sequence did not finish in the expected time");
    end

    initial begin
        clk_i     = 1'b0;
        rst_i     = 1'b1;
        cen_i     = 1'b0;
        vid_rgb_i = rgb_t'(24'h5A_3C_96);    // Ignored by the DUT
        blank_i   = '0;
        sync_i    = '0;
        lfsr_q    = 16'd37;
        exp_rgb   = '0;
        exp_sync  = '0;
        test_name = "reset";
        model_reset();
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // Held enable after reset, outputs stay zero
        repeat (4) drive_cycle(1'b0, blank_t'(rand_bits(2)));

        test_name = "tall_frame";
        run_frame(280, 1000, 1'b0);

        test_name = "flake_wrap";
        repeat (TINY_FRAMES) run_frame(2, 64, 1'b0);

        // Flake 0 back near the top at x 137
        test_name = "wrap_view";
        run_frame(16, 160, 1'b0);

        test_name = "enable_gaps";
        run_frame(40, 200, 1'b1);

        // Let the last enabled result reach the compare
        repeat (2) drive_cycle(1'b0, blank_t'(2'b11));
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: snow_scene_top.f
+incdir+common
+incdir+tb
common/scene_pkg.sv
rtl/raster_tracker.sv
snowflake/snowflake_unit.sv
rtl/pacman_sprite.sv
rtl/scene_compositor.sv
rtl/snow_scene_top.sv
tb/snow_scene_tb.sv
